// ==== Makefile ====
# Verilator simulation of the global register block

SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv)

all: run

obj_dir/Vtb_glbl_reg: build.f $(SRCS)
	verilator --binary -j 0 --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module tb_glbl_reg -f build.f -Mdir obj_dir

run: obj_dir/Vtb_glbl_reg
	./obj_dir/Vtb_glbl_reg | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== build.f ====
+incdir+src
src/glbl_reg_pkg.sv
src/glbl_bus_decode.sv
src/glbl_cfg_regs.sv
src/glbl_intr_ctrl.sv
src/glbl_read_return.sv
src/glbl_reg_top.sv
tb/tb_glbl_reg.sv

// ==== src/glbl_bus_decode.sv ====
// Register bus front end: address decode, access strobes and acknowledge
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module glbl_bus_decode
   import glbl_reg_pkg::*;
(
   input  wire       mclk,
   input  wire       s_reset_n,
   input  wire       reg_cs,
   input  wire       reg_wr,
   input  wire       [`GLBL_ADDR_W-1:0] reg_addr,
   output reg_sel_e  reg_sel,
   output logic      wr_stb,
   output logic      acc_stb,
   output logic      reg_ack
);

   // Offset into the scratch bank
   logic [2:0] scr_idx;

   assign scr_idx = reg_addr[2:0];

   // --------------------
   // Address decode
   // --------------------
   always_comb begin
      case (reg_addr)
         `GLBL_ADDR_CHIP_ID:   reg_sel = SEL_CHIP_ID;
         `GLBL_ADDR_RST_CTRL:  reg_sel = SEL_RST_CTRL;
         `GLBL_ADDR_CORE_CFG:  reg_sel = SEL_CORE_CFG;
         `GLBL_ADDR_INTR_MASK: reg_sel = SEL_INTR_MASK;
         `GLBL_ADDR_INTR_STAT: reg_sel = SEL_INTR_STAT;
         `GLBL_ADDR_MFUNC:     reg_sel = SEL_MFUNC;
         `GLBL_ADDR_MAILBOX:   reg_sel = SEL_MAILBOX;
         default: begin
            // Scratch bank 16..23, everything else reserved
            if (reg_addr[4:3] == `GLBL_ADDR_SCRATCH0 >> 3) begin
               reg_sel = reg_sel_e'(4'(SEL_SCRATCH0) + {1'b0, scr_idx});
            end else begin
               reg_sel = SEL_NONE;
            end
         end
      endcase
   end

   // --------------------
   // Strobes and ack
   // --------------------
   // Access cycle is the one before ack rises, once per access
   assign acc_stb = reg_cs & ~reg_ack;
   assign wr_stb  = acc_stb & reg_wr;

   // Single-cycle ack pulse
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= acc_stb;
      end
   end

   // Held select means back-to-back accesses, never a stretched ack
   a_ack_pulse: assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |=> !reg_ack);

   // Master must present a clean address during the access
   a_addr_known: assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_cs |-> !$isunknown(reg_addr));

endmodule

`default_nettype wire

// ==== src/glbl_cfg_regs.sv ====
// Configuration storage: chip id, reset control, core config, pin select, mailbox, scratch
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module glbl_cfg_regs
   import glbl_reg_pkg::*;
(
   input  wire              mclk,
   input  wire              s_reset_n,
   input  wire reg_sel_e    reg_sel,
   input  wire              wr_stb,
   input  wire reg_data_t   wdata,
   input  wire reg_be_t     be,
   output reg_data_t        rd_val,
   output logic [1:0]       cpu_core_rst_n,
   output logic             cpu_intf_rst_n,
   output logic             qspim_rst_n,
   output logic             sspim_rst_n,
   output logic [1:0]       uart_rst_n,
   output logic             i2cm_rst_n,
   output logic             usb_rst_n,
   output logic             soft_irq,
   output logic [2:0]       user_irq,
   output logic [15:0]      cfg_riscv_ctrl,
   output reg_data_t        cfg_multi_func_sel
);

   reg_data_t         rst_ctrl;
   reg_data_t         core_cfg;
   reg_data_t         mfunc_sel;
   reg_data_t         mailbox;
   reg_data_t [7:0]   scratch;

   // Byte lanes expanded to bit mask
   reg_data_t         be_mask;
   logic              scr_hit;
   logic [2:0]        scr_idx;

   assign be_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   assign scr_hit = (reg_sel >= SEL_SCRATCH0) && (reg_sel <= SEL_SCRATCH7);
   assign scr_idx = 3'(reg_sel - SEL_SCRATCH0);

   // --------------------
   // Register storage
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl   <= `GLBL_RST_CTRL_INIT;
         core_cfg   <= '0;
         mfunc_sel  <= `GLBL_MFUNC_INIT;
         mailbox    <= '0;
         // Signature, release and revision words in the low three
         scratch[0] <= `GLBL_SIGNATURE;
         scratch[1] <= `GLBL_RELEASE_DATE;
         scratch[2] <= `GLBL_REVISION;
         scratch[7:3] <= '0;
      end else if (wr_stb) begin
         case (reg_sel)
            SEL_RST_CTRL: rst_ctrl  <= (rst_ctrl & ~be_mask) | (wdata & be_mask);
            SEL_CORE_CFG: core_cfg  <= (core_cfg & ~be_mask) | (wdata & be_mask);
            SEL_MFUNC:    mfunc_sel <= (mfunc_sel & ~be_mask) | (wdata & be_mask);
            SEL_MAILBOX:  mailbox   <= (mailbox & ~be_mask) | (wdata & be_mask);
            default: begin
               if (scr_hit) begin
                  scratch[scr_idx] <= (scratch[scr_idx] & ~be_mask) | (wdata & be_mask);
               end
            end
         endcase
      end
   end

   // --------------------
   // Read value
   // --------------------
   // Zero for selects owned elsewhere
   always_comb begin
      case (reg_sel)
         SEL_CHIP_ID:  rd_val = `GLBL_CHIP_ID;
         SEL_RST_CTRL: rd_val = rst_ctrl;
         SEL_CORE_CFG: rd_val = core_cfg;
         SEL_MFUNC:    rd_val = mfunc_sel;
         SEL_MAILBOX:  rd_val = mailbox;
         default:      rd_val = scr_hit ? scratch[scr_idx] : '0;
      endcase
   end

   // Reset outputs, active low straight from register bits
   assign cpu_intf_rst_n = rst_ctrl[`GLBL_RST_CPU_INTF];
   assign qspim_rst_n    = rst_ctrl[`GLBL_RST_QSPIM];
   assign sspim_rst_n    = rst_ctrl[`GLBL_RST_SSPIM];
   assign uart_rst_n     = {rst_ctrl[`GLBL_RST_UART1], rst_ctrl[`GLBL_RST_UART0]};
   assign i2cm_rst_n     = rst_ctrl[`GLBL_RST_I2CM];
   assign usb_rst_n      = rst_ctrl[`GLBL_RST_USB];
   assign cpu_core_rst_n = rst_ctrl[`GLBL_RST_CORE_HI:`GLBL_RST_CORE_LO];

   // Core interrupts and control field
   assign user_irq       = core_cfg[`GLBL_CFG_UIRQ_HI:`GLBL_CFG_UIRQ_LO];
   assign soft_irq       = core_cfg[`GLBL_CFG_SOFT_IRQ];
   assign cfg_riscv_ctrl = core_cfg[`GLBL_CFG_CTRL_HI:`GLBL_CFG_CTRL_LO];
   assign cfg_multi_func_sel = mfunc_sel;

   // Chip id is read-only, a write there leaves all storage alone
   a_chip_id_ro: assert property (@(posedge mclk) disable iff (!s_reset_n)
      (wr_stb && reg_sel == SEL_CHIP_ID)
      |=> $stable({rst_ctrl, core_cfg, mfunc_sel, mailbox, scratch}));

endmodule

`default_nettype wire

// ==== src/glbl_intr_ctrl.sv ====
// Interrupt storage: mask, sticky status and masked interrupt lines
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module glbl_intr_ctrl
   import glbl_reg_pkg::*;
(
   input  wire              mclk,
   input  wire              s_reset_n,
   input  wire reg_sel_e    reg_sel,
   input  wire              wr_stb,
   input  wire reg_data_t   wdata,
   input  wire reg_be_t     be,
   input  wire [2:0]        timer_intr,
   input  wire              i2cm_intr,
   input  wire              usb_intr,
   input  wire irq_vec_t    gpio_intr,
   output reg_data_t        rd_val,
   output irq_vec_t         irq_lines
);

   irq_vec_t   hw_req;
   irq_vec_t   intr_mask;
   irq_vec_t   intr_stat;
   irq_vec_t   stat_clr;
   reg_data_t  be_mask;

   assign be_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};

   // --------------------
   // Request map
   // --------------------
   // GPIO 7:0 not routed, those slots stay zero
   always_comb begin
      hw_req = '0;
      hw_req[`GLBL_IRQ_TIMER_HI:`GLBL_IRQ_TIMER_LO] = timer_intr;
      hw_req[`GLBL_IRQ_I2CM] = i2cm_intr;
      hw_req[`GLBL_IRQ_USB]  = usb_intr;
      hw_req[`GLBL_IRQ_GPIO_HI:`GLBL_IRQ_GPIO_LO] =
         gpio_intr[`GLBL_IRQ_GPIO_HI:`GLBL_IRQ_GPIO_LO];
   end

   // Write-one-clear under byte lanes
   assign stat_clr = (wr_stb && reg_sel == SEL_INTR_STAT) ? (wdata & be_mask) : '0;

   // --------------------
   // Mask and status
   // --------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask <= '0;
         intr_stat <= '0;
      end else begin
         if (wr_stb && reg_sel == SEL_INTR_MASK) begin
            intr_mask <= (intr_mask & ~be_mask) | (wdata & be_mask);
         end
         // Set beats clear on the same edge
         intr_stat <= hw_req | (intr_stat & ~stat_clr);
      end
   end

   always_comb begin
      case (reg_sel)
         SEL_INTR_MASK: rd_val = intr_mask;
         SEL_INTR_STAT: rd_val = intr_stat;
         default:       rd_val = '0;
      endcase
   end

   assign irq_lines = intr_mask & intr_stat;

   // Pending bits drop only under a write-one clear
   a_stat_sticky: assert property (@(posedge mclk) disable iff (!s_reset_n)
      ((($past(intr_stat) & ~$past(stat_clr)) & ~intr_stat) == '0));

   // Unmapped request slots never latch
   a_rsvd_zero: assert property (@(posedge mclk) disable iff (!s_reset_n)
      intr_stat[`GLBL_IRQ_RSVD_HI:`GLBL_IRQ_RSVD_LO] == '0);

endmodule

`default_nettype wire

// ==== src/glbl_read_return.sv ====
// Read return stage: merges storage read values into the registered read data
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module glbl_read_return
   import glbl_reg_pkg::*;
(
   input  wire              mclk,
   input  wire              s_reset_n,
   input  wire              acc_stb,
   input  wire reg_data_t   cfg_rd_val,
   input  wire reg_data_t   intr_rd_val,
   output reg_data_t        reg_rdata
);

   // --------------------
   // Merge
   // --------------------
   // Each stage drives zero for selects it does not own,
   // so an OR picks the single owner
   reg_data_t rd_merged;

   assign rd_merged = cfg_rd_val | intr_rd_val;

   // --------------------
   // Capture
   // --------------------
   // Sampled on the access cycle, valid with ack
   // Holds between accesses
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_rdata <= '0;
      end else if (acc_stb) begin
         reg_rdata <= rd_merged;
      end
   end

   // Both stages never answer the same select
   a_one_owner: assert property (@(posedge mclk) disable iff (!s_reset_n)
      acc_stb |-> ((cfg_rd_val & intr_rd_val) == '0));

endmodule

`default_nettype wire

// ==== src/glbl_reg_defs.svh ====
// Global register block constants: widths, addresses, reset values and field positions
`ifndef GLBL_REG_DEFS_SVH
`define GLBL_REG_DEFS_SVH

// --------------------
// Bus widths
// --------------------
`define GLBL_DATA_W          32
`define GLBL_ADDR_W          5
`define GLBL_BE_W            4

// --------------------
// Word addresses
// --------------------
`define GLBL_ADDR_CHIP_ID    5'd0
`define GLBL_ADDR_RST_CTRL   5'd1
`define GLBL_ADDR_CORE_CFG   5'd2
`define GLBL_ADDR_INTR_MASK  5'd3
`define GLBL_ADDR_INTR_STAT  5'd4
`define GLBL_ADDR_MFUNC      5'd5
`define GLBL_ADDR_MAILBOX    5'd15
// Scratch bank base, eight words, aligned to 8
`define GLBL_ADDR_SCRATCH0   5'd16

// --------------------
// Reset and constant values
// --------------------
// Manufacturer 0x8268, two cores, chip 5, rev 0x01
`define GLBL_CHIP_ID         32'h8268_2501
// Core interface and flash out of reset, rest held
`define GLBL_RST_CTRL_INIT   32'h0000_0003
// UART master enabled at power up
`define GLBL_MFUNC_INIT      32'h8000_0000
`define GLBL_SIGNATURE       32'h8273_8343
`define GLBL_RELEASE_DATE    32'h0000_0100
`define GLBL_REVISION        32'h0005_1000

// --------------------
// Reset control fields
// --------------------
`define GLBL_RST_CPU_INTF    0
`define GLBL_RST_QSPIM       1
`define GLBL_RST_SSPIM       2
`define GLBL_RST_UART0       3
`define GLBL_RST_I2CM        4
`define GLBL_RST_USB         5
`define GLBL_RST_UART1       6
`define GLBL_RST_CORE_LO     8
`define GLBL_RST_CORE_HI     9

// Core configuration fields
`define GLBL_CFG_UIRQ_LO     0
`define GLBL_CFG_UIRQ_HI     2
`define GLBL_CFG_SOFT_IRQ    3
`define GLBL_CFG_CTRL_LO     16
`define GLBL_CFG_CTRL_HI     31

// Interrupt request map
`define GLBL_IRQ_TIMER_LO    0
`define GLBL_IRQ_TIMER_HI    2
`define GLBL_IRQ_I2CM        3
`define GLBL_IRQ_USB         4
`define GLBL_IRQ_RSVD_LO     5
`define GLBL_IRQ_RSVD_HI     7
`define GLBL_IRQ_GPIO_LO     8
`define GLBL_IRQ_GPIO_HI     31

`endif

// ==== src/glbl_reg_pkg.sv ====
// Global register block shared types and register-select encoding
`default_nettype none

`include "glbl_reg_defs.svh"

package glbl_reg_pkg;

   // --------------------
   // Bus payload types
   // --------------------
   // One register word
   typedef logic [`GLBL_DATA_W-1:0] reg_data_t;

   // Word address on the register bus
   typedef logic [`GLBL_ADDR_W-1:0] reg_addr_t;

   // One enable per byte lane
   typedef logic [`GLBL_BE_W-1:0]   reg_be_t;

   // Interrupt request / status / line vector
   typedef logic [`GLBL_DATA_W-1:0] irq_vec_t;

   // --------------------
   // Register select
   // --------------------
   // Decoded once, shared by all storage stages
   // Scratch selects are contiguous, index by offset from SEL_SCRATCH0
   typedef enum logic [3:0] {
      SEL_CHIP_ID   = 4'd0,
      SEL_RST_CTRL  = 4'd1,
      SEL_CORE_CFG  = 4'd2,
      SEL_INTR_MASK = 4'd3,
      SEL_INTR_STAT = 4'd4,
      SEL_MFUNC     = 4'd5,
      SEL_MAILBOX   = 4'd6,
      SEL_SCRATCH0  = 4'd7,
      SEL_SCRATCH1  = 4'd8,
      SEL_SCRATCH2  = 4'd9,
      SEL_SCRATCH3  = 4'd10,
      SEL_SCRATCH4  = 4'd11,
      SEL_SCRATCH5  = 4'd12,
      SEL_SCRATCH6  = 4'd13,
      SEL_SCRATCH7  = 4'd14,
      // Reserved or dropped address, reads zero
      SEL_NONE      = 4'd15
   } reg_sel_e;

endpackage

`default_nettype wire

// ==== src/glbl_reg_top.sv ====
// Global register block top: bus decode, storage stages and read return
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module glbl_reg_top
   import glbl_reg_pkg::*;
(
   input  wire              mclk,
   input  wire              s_reset_n,

   // Register bus
   input  wire              reg_cs,
   input  wire              reg_wr,
   input  wire reg_addr_t   reg_addr,
   input  wire reg_data_t   reg_wdata,
   input  wire reg_be_t     reg_be,
   output reg_data_t        reg_rdata,
   output logic             reg_ack,

   // Hardware interrupt requests
   input  wire [2:0]        timer_intr,
   input  wire              i2cm_intr,
   input  wire              usb_intr,
   input  wire irq_vec_t    gpio_intr,
   output irq_vec_t         irq_lines,

   // Block resets, active low
   output logic [1:0]       cpu_core_rst_n,
   output logic             cpu_intf_rst_n,
   output logic             qspim_rst_n,
   output logic             sspim_rst_n,
   output logic [1:0]       uart_rst_n,
   output logic             i2cm_rst_n,
   output logic             usb_rst_n,

   // Core configuration
   output logic             soft_irq,
   output logic [2:0]       user_irq,
   output logic [15:0]      cfg_riscv_ctrl,
   output reg_data_t        cfg_multi_func_sel
);

   reg_sel_e    reg_sel;
   logic        wr_stb;
   logic        acc_stb;
   reg_data_t   cfg_rd_val;
   reg_data_t   intr_rd_val;

   // --------------------
   // Request decode
   // --------------------
   glbl_bus_decode u_bus_decode (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_cs    (reg_cs),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_sel   (reg_sel),
      .wr_stb    (wr_stb),
      .acc_stb   (acc_stb),
      .reg_ack   (reg_ack)
   );

   // --------------------
   // Storage, side by side
   // --------------------
   glbl_cfg_regs u_cfg_regs (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .reg_sel            (reg_sel),
      .wr_stb             (wr_stb),
      .wdata              (reg_wdata),
      .be                 (reg_be),
      .rd_val             (cfg_rd_val),
      .cpu_core_rst_n     (cpu_core_rst_n),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .uart_rst_n         (uart_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel)
   );

   glbl_intr_ctrl u_intr_ctrl (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_sel    (reg_sel),
      .wr_stb     (wr_stb),
      .wdata      (reg_wdata),
      .be         (reg_be),
      .timer_intr (timer_intr),
      .i2cm_intr  (i2cm_intr),
      .usb_intr   (usb_intr),
      .gpio_intr  (gpio_intr),
      .rd_val     (intr_rd_val),
      .irq_lines  (irq_lines)
   );

   // --------------------
   // Read return
   // --------------------
   glbl_read_return u_read_return (
      .mclk        (mclk),
      .s_reset_n   (s_reset_n),
      .acc_stb     (acc_stb),
      .cfg_rd_val  (cfg_rd_val),
      .intr_rd_val (intr_rd_val),
      .reg_rdata   (reg_rdata)
   );

endmodule

`default_nettype wire

// ==== tb/tb_glbl_reg.sv ====
// Global register block testbench: bus tasks, reference model and self-checking sequence
`timescale 1ns/100ps
`default_nettype none

`include "glbl_reg_defs.svh"

module tb_glbl_reg
   import glbl_reg_pkg::*;
();

   // Packed view of all reset and core config outputs
   typedef logic [28:0] ctrl_vec_t;

   localparam int ACK_TIMEOUT = 16;

   logic          mclk;
   logic          s_reset_n;
   logic          reg_cs;
   logic          reg_wr;
   reg_addr_t     reg_addr;
   reg_data_t     reg_wdata;
   reg_be_t       reg_be;
   reg_data_t     reg_rdata;
   logic          reg_ack;
   logic [2:0]    timer_intr;
   logic          i2cm_intr;
   logic          usb_intr;
   irq_vec_t      gpio_intr;
   irq_vec_t      irq_lines;
   logic [1:0]    cpu_core_rst_n;
   logic          cpu_intf_rst_n;
   logic          qspim_rst_n;
   logic          sspim_rst_n;
   logic [1:0]    uart_rst_n;
   logic          i2cm_rst_n;
   logic          usb_rst_n;
   logic          soft_irq;
   logic [2:0]    user_irq;
   logic [15:0]   cfg_riscv_ctrl;
   reg_data_t     cfg_multi_func_sel;

   // Reference model state
   reg_data_t     model_mem [0:31];
   irq_vec_t      model_stat;

   // Error counters, one per kind
   int            word_errs;
   int            irq_errs;
   int            ctrl_errs;
   int            other_errs;
   int            num_checks;

   // --------------------
   // Clock and DUT
   // --------------------
   initial begin
      mclk = 1'b0;
      forever begin
         #10 mclk = ~mclk;
      end
   end

   glbl_reg_top u_glbl_reg_top (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .reg_cs             (reg_cs),
      .reg_wr             (reg_wr),
      .reg_addr           (reg_addr),
      .reg_wdata          (reg_wdata),
      .reg_be             (reg_be),
      .reg_rdata          (reg_rdata),
      .reg_ack            (reg_ack),
      .timer_intr         (timer_intr),
      .i2cm_intr          (i2cm_intr),
      .usb_intr           (usb_intr),
      .gpio_intr          (gpio_intr),
      .irq_lines          (irq_lines),
      .cpu_core_rst_n     (cpu_core_rst_n),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .uart_rst_n         (uart_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel)
   );

   // --------------------
   // Reference model
   // --------------------
   // One byte lane per enable bit
   function automatic reg_data_t lane_mask(reg_be_t be);
      reg_data_t m;
      m = '0;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            m[i*8 +: 8] = 8'hff;
         end
      end
      return m;
   endfunction

   // Plain storage words, status handled apart
   function automatic bit is_writable(reg_addr_t addr);
      return (addr == `GLBL_ADDR_RST_CTRL) || (addr == `GLBL_ADDR_CORE_CFG) ||
             (addr == `GLBL_ADDR_INTR_MASK) || (addr == `GLBL_ADDR_MFUNC) ||
             (addr == `GLBL_ADDR_MAILBOX) || (addr >= 5'd16 && addr <= 5'd23);
   endfunction

   function automatic void model_reset();
      for (int i = 0; i < 32; i++) begin
         model_mem[i] = '0;
      end
      model_mem[`GLBL_ADDR_RST_CTRL] = `GLBL_RST_CTRL_INIT;
      model_mem[`GLBL_ADDR_MFUNC]    = `GLBL_MFUNC_INIT;
      model_mem[16] = `GLBL_SIGNATURE;
      model_mem[17] = `GLBL_RELEASE_DATE;
      model_mem[18] = `GLBL_REVISION;
      model_stat = '0;
   endfunction

   // Byte merge, write-one clear, read-only and reserved rules
   function automatic void model_write(reg_addr_t addr, reg_data_t data, reg_be_t be);
      reg_data_t m;
      m = lane_mask(be);
      if (addr == `GLBL_ADDR_INTR_STAT) begin
         model_stat = model_stat & ~(data & m);
      end else if (is_writable(addr)) begin
         model_mem[addr] = (model_mem[addr] & ~m) | (data & m);
      end
   endfunction

   // Expected read word; reserved entries never leave zero
   function automatic reg_data_t ref_read(reg_addr_t addr);
      reg_data_t val;
      case (addr)
         `GLBL_ADDR_CHIP_ID:   val = `GLBL_CHIP_ID;
         `GLBL_ADDR_INTR_STAT: val = model_stat;
         default:              val = model_mem[addr];
      endcase
      return val;
   endfunction

   // Timers 2:0, I2C 3, USB 4, GPIO 31:8
   function automatic irq_vec_t req_map(logic [2:0] timer, logic i2c, logic usb,
                                        irq_vec_t gpio);
      irq_vec_t v;
      v = '0;
      v[2:0]  = timer;
      v[3]    = i2c;
      v[4]    = usb;
      v[31:8] = gpio[31:8];
      return v;
   endfunction

   function automatic ctrl_vec_t ctrl_expected();
      reg_data_t r;
      reg_data_t c;
      r = model_mem[`GLBL_ADDR_RST_CTRL];
      c = model_mem[`GLBL_ADDR_CORE_CFG];
      return {r[9:8], r[0], r[1], r[2], r[6], r[3], r[4], r[5], c[3], c[2:0], c[31:16]};
   endfunction

   function automatic ctrl_vec_t ctrl_actual();
      return {cpu_core_rst_n, cpu_intf_rst_n, qspim_rst_n, sspim_rst_n, uart_rst_n,
              i2cm_rst_n, usb_rst_n, soft_irq, user_irq, cfg_riscv_ctrl};
   endfunction

   // --------------------
   // Compare tasks
   // --------------------
   task automatic check_word(string name, reg_data_t exp, reg_data_t act);
      num_checks++;
      if (act !== exp) begin
         word_errs++;
         $display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_irq(string name, irq_vec_t exp, irq_vec_t act);
      num_checks++;
      if (act !== exp) begin
         irq_errs++;
         $display("Mismatch %s irq_lines: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_ctrl(string name, ctrl_vec_t exp, ctrl_vec_t act);
      num_checks++;
      if (act !== exp) begin
         ctrl_errs++;
         $display("Mismatch %s ctrl: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   // Outputs that follow register state
   task automatic check_outputs(string name);
      check_irq(name, model_mem[`GLBL_ADDR_INTR_MASK] & model_stat, irq_lines);
      check_ctrl(name, ctrl_expected(), ctrl_actual());
      check_word({name, " mfunc"}, model_mem[`GLBL_ADDR_MFUNC], cfg_multi_func_sel);
   endtask

   // --------------------
   // Bus tasks
   // --------------------
   // Starts and ends on a falling edge
   task automatic bus_access(logic wr, reg_addr_t addr, reg_data_t data, reg_be_t be,
                             output reg_data_t rdata);
      int cycles;
      cycles    = 0;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = addr;
      reg_wdata = data;
      reg_be    = be;
      @(negedge mclk);
      while (!reg_ack && cycles < ACK_TIMEOUT) begin
         @(negedge mclk);
         cycles++;
      end
      rdata  = reg_rdata;
      reg_cs = 1'b0;
      reg_wr = 1'b0;
      if (!reg_ack) begin
         other_errs++;
         $display("Timeout: no acknowledge within %0d cycles at address %0d",
                  ACK_TIMEOUT, addr);
      end
   endtask

   task automatic bus_write(string name, reg_addr_t addr, reg_data_t data, reg_be_t be);
      reg_data_t unused;
      bus_access(1'b1, addr, data, be, unused);
      model_write(addr, data, be);
      check_outputs($sformatf("%s wr @%0d", name, addr));
   endtask

   task automatic bus_read(string name, reg_addr_t addr);
      reg_data_t rdata;
      bus_access(1'b0, addr, '0, '0, rdata);
      check_word($sformatf("%s rd @%0d", name, addr), ref_read(addr), rdata);
      check_outputs($sformatf("%s rd @%0d", name, addr));
   endtask

   // One-cycle request pulse, status latches on the edge between
   task automatic pulse_irq(logic [2:0] timer, logic i2c, logic usb, irq_vec_t gpio);
      timer_intr = timer;
      i2cm_intr  = i2c;
      usb_intr   = usb;
      gpio_intr  = gpio;
      @(negedge mclk);
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      gpio_intr  = '0;
      model_stat = model_stat | req_map(timer, i2c, usb, gpio);
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin : main_seq
      reg_addr_t addr;
      reg_addr_t rsvd_addrs [4];
      int        total;
      s_reset_n  = 1'b0;
      reg_cs     = 1'b0;
      reg_wr     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_be     = '0;
      timer_intr = '0;
      i2cm_intr  = 1'b0;
      usb_intr   = 1'b0;
      gpio_intr  = '0;
      word_errs  = 0;
      irq_errs   = 0;
      ctrl_errs  = 0;
      other_errs = 0;
      num_checks = 0;
      void'($urandom(76));
      model_reset();
      repeat (16) @(posedge mclk);
      @(negedge mclk);
      s_reset_n = 1'b1;
      @(negedge mclk);

      // Reset values
      if (reg_ack !== 1'b0) begin
         other_errs++;
         $display("Acknowledge is not low after reset");
      end
      check_outputs("reset");
      bus_read("reset", `GLBL_ADDR_CHIP_ID);
      bus_read("reset", `GLBL_ADDR_RST_CTRL);
      bus_read("reset", `GLBL_ADDR_MFUNC);
      for (int i = 16; i < 19; i++) begin
         bus_read("reset", 5'(i));
      end

      // Byte-enabled writes, read-only and reserved words
      bus_write("bytes", `GLBL_ADDR_MAILBOX, 32'hdead_beef, 4'hf);
      bus_write("bytes", `GLBL_ADDR_MAILBOX, 32'h1234_5678, 4'b0101);
      bus_read("bytes", `GLBL_ADDR_MAILBOX);
      bus_write("bytes", 5'd19, 32'hcafe_f00d, 4'b1001);
      bus_read("bytes", 5'd19);
      bus_write("bytes", 5'd16, 32'h0bad_0bad, 4'b0010);
      bus_read("bytes", 5'd16);
      bus_write("bytes", `GLBL_ADDR_CHIP_ID, 32'hffff_ffff, 4'hf);
      bus_read("bytes", `GLBL_ADDR_CHIP_ID);
      // Dropped clock and strap words
      rsvd_addrs = '{5'd6, 5'd7, 5'd13, 5'd14};
      foreach (rsvd_addrs[k]) begin
         bus_write("rsvd", rsvd_addrs[k], 32'h5a5a_5a5a, 4'hf);
         bus_read("rsvd", rsvd_addrs[k]);
      end
      bus_write("bytes", 5'd12, 32'h5a5a_5a5a, 4'hf);
      bus_read("bytes", 5'd12);
      bus_write("bytes", 5'd31, 32'ha5a5_a5a5, 4'hf);
      bus_read("bytes", 5'd31);

      // Control outputs by field
      bus_write("ctrl", `GLBL_ADDR_RST_CTRL, 32'h0000_0355, 4'hf);
      bus_write("ctrl", `GLBL_ADDR_RST_CTRL, 32'h0000_02aa, 4'b0011);
      bus_write("ctrl", `GLBL_ADDR_CORE_CFG, 32'ha5c3_000d, 4'hf);
      bus_write("ctrl", `GLBL_ADDR_CORE_CFG, 32'h3c00_0002, 4'b1001);
      bus_write("ctrl", `GLBL_ADDR_MFUNC, 32'h0000_0f0f, 4'b0011);
      bus_read("ctrl", `GLBL_ADDR_CORE_CFG);

      // Sticky status, mask and partial clear
      bus_write("irq", `GLBL_ADDR_INTR_MASK, 32'h00ff_001b, 4'hf);
      pulse_irq(3'b101, 1'b1, 1'b0, 32'habcd_12ff);
      check_outputs("irq pulse 1");
      pulse_irq(3'b010, 1'b0, 1'b1, 32'h0000_0400);
      check_outputs("irq pulse 2");
      repeat (3) @(negedge mclk);
      check_outputs("irq hold");
      bus_read("irq", `GLBL_ADDR_INTR_STAT);
      bus_read("irq", `GLBL_ADDR_INTR_MASK);
      bus_write("irq", `GLBL_ADDR_INTR_STAT, 32'hffff_ffff, 4'b0110);
      bus_read("irq", `GLBL_ADDR_INTR_STAT);
      bus_write("irq", `GLBL_ADDR_INTR_STAT, 32'hffff_ffff, 4'hf);
      bus_read("irq", `GLBL_ADDR_INTR_STAT);

      // Random accesses with interrupt pulses between them
      for (int n = 0; n < 200; n++) begin
         addr = 5'($urandom_range(31, 0));
         if ($urandom_range(3, 0) == 0) begin
            pulse_irq(3'($urandom), 1'($urandom), 1'($urandom), $urandom);
         end
         if (1'($urandom)) begin
            bus_write("random", addr, $urandom, 4'($urandom));
         end else begin
            bus_read("random", addr);
         end
      end

      total = word_errs + irq_errs + ctrl_errs + other_errs;
      $display("Checks %0d, errors: word %0d, irq %0d, ctrl %0d, other %0d",
               num_checks, word_errs, irq_errs, ctrl_errs, other_errs);
      if (total == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
